// File: logic/wdt_apb_regs.sv
// Watchdog APB register file
// Decodes single-access APB transfers, holds enable, mode and periods,
// turns PET and STATUS writes into restart and service pulses and
// derives both timer enables, gating timer 2 in cascade mode

`timescale 1ns/1ns
`include "wdt_macros.svh"

module wdt_apb_regs
  import wdt_pkg::*;
(
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  apb_req_t       apb_req_i,
  output apb_rsp_t       apb_rsp_o,
  input  wdt_status_t    status_i,
  output wdt_timer_ctl_t t1_ctl_o,
  output wdt_timer_ctl_t t2_ctl_o,
  output wdt_service_t   service_o,
  output logic           cascade_o
);

  logic                  access;
  logic                  wr_en;
  logic                  sel_ctrl;
  logic                  sel_t1;
  logic                  sel_t2;
  logic                  sel_pet;
  logic                  sel_status;
  logic                  mapped;
  logic                  wdt_en_q;
  logic                  timer2_en_q;
  logic [`WDT_CNT_W-1:0] t1_period_q;
  logic [`WDT_CNT_W-1:0] t2_period_q;
  logic [31:0]           rdata;

  //////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////

  // Every transfer completes in its first access cycle
  assign access = apb_req_i.psel && apb_req_i.penable;

  assign sel_ctrl   = (apb_req_i.paddr == `WDT_CTRL_OFF);
  assign sel_t1     = (apb_req_i.paddr == `WDT_T1_PERIOD_OFF);
  assign sel_t2     = (apb_req_i.paddr == `WDT_T2_PERIOD_OFF);
  assign sel_pet    = (apb_req_i.paddr == `WDT_PET_OFF);
  assign sel_status = (apb_req_i.paddr == `WDT_STATUS_OFF);
  assign mapped     = sel_ctrl | sel_t1 | sel_t2 | sel_pet | sel_status;

  // Unmapped offsets never reach a register
  assign wr_en = access && apb_req_i.pwrite && mapped;

  //////////////////////////////////////////////////
  // Configuration registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wdt_en_q    <= 1'b0;
      timer2_en_q <= 1'b0;
      t1_period_q <= '0;
      t2_period_q <= '0;
    end else if (wr_en) begin
      if (sel_ctrl) begin
        wdt_en_q    <= apb_req_i.pwdata[0];
        timer2_en_q <= apb_req_i.pwdata[1];
      end
      if (sel_t1) begin
        t1_period_q <= apb_req_i.pwdata[`WDT_CNT_W-1:0];
      end
      if (sel_t2) begin
        t2_period_q <= apb_req_i.pwdata[`WDT_CNT_W-1:0];
      end
    end
  end

  //////////////////////////////////////////////////
  // Pulses and timer controls
  //////////////////////////////////////////////////

  // W1C on STATUS, acts at the edge closing the access cycle
  assign service_o.t1 = wr_en && sel_status && apb_req_i.pwdata[0];
  assign service_o.t2 = wr_en && sel_status && apb_req_i.pwdata[1];

  // Pet or service restarts the matching timer
  assign t1_ctl_o.restart = (wr_en && sel_pet && apb_req_i.pwdata[0]) || service_o.t1;
  assign t2_ctl_o.restart = (wr_en && sel_pet && apb_req_i.pwdata[1]) || service_o.t2;

  assign t1_ctl_o.period = t1_period_q;
  assign t2_ctl_o.period = t2_period_q;

  assign t1_ctl_o.en = wdt_en_q;
  // Cascade mode, timer 2 runs only while timer 1 sits unserviced
  assign t2_ctl_o.en = wdt_en_q && (timer2_en_q || status_i.t1_timeout);

  assign cascade_o = !timer2_en_q;

  //////////////////////////////////////////////////
  // Read path
  //////////////////////////////////////////////////

  always_comb begin
    rdata = '0;
    if (sel_ctrl) begin
      rdata[1:0] = {timer2_en_q, wdt_en_q};
    end else if (sel_t1) begin
      rdata = 32'(t1_period_q);
    end else if (sel_t2) begin
      rdata = 32'(t2_period_q);
    end else if (sel_status) begin
      rdata[1:0] = {status_i.t2_timeout, status_i.t1_timeout};
    end
    // PET reads back zero
  end

  assign apb_rsp_o.prdata  = rdata;
  assign apb_rsp_o.pready  = access;
  assign apb_rsp_o.pslverr = access && !mapped;

endmodule

// File: logic/wdt_macros.svh
// Watchdog subsystem constants
// Counter width, APB address width and the register map offsets

`ifndef WDT_MACROS_SVH
`define WDT_MACROS_SVH

// Width of both counters and both period registers
`define WDT_CNT_W 32

// APB address bus width
`define WDT_ADDR_W 8

// Register map
`define WDT_CTRL_OFF      8'h00
`define WDT_T1_PERIOD_OFF 8'h04
`define WDT_T2_PERIOD_OFF 8'h08
`define WDT_PET_OFF       8'h0C
`define WDT_STATUS_OFF    8'h10

`endif

// File: logic/wdt_pkg.sv
// Watchdog subsystem types
// APB request and response, per-timer control and result, the sticky
// status bits and the service pulses shared by all watchdog blocks

`include "wdt_macros.svh"

package wdt_pkg;

  // APB requester side, one transfer at a time
  typedef struct packed {
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`WDT_ADDR_W-1:0] paddr;
    logic [31:0]            pwdata;
  } apb_req_t;

  // APB completer side
  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // Everything one timer needs from the register file
  typedef struct packed {
    logic                  en;
    logic                  restart;
    logic [`WDT_CNT_W-1:0] period;
  } wdt_timer_ctl_t;

  // What one timer reports back
  typedef struct packed {
    logic                  timeout;
    logic [`WDT_CNT_W-1:0] count;
  } wdt_timer_res_t;

  // Sticky status, bit order matches the STATUS register
  typedef struct packed {
    logic t2_timeout;
    logic t1_timeout;
  } wdt_status_t;

  // One-cycle write-one-to-clear pulses
  typedef struct packed {
    logic t2;
    logic t1;
  } wdt_service_t;

endpackage

// File: logic/wdt_status_combiner.sv
// Watchdog status combiner
// Catches rising timeouts of both timers in sticky status bits, clears
// them on service, raises the interrupt from either bit and latches
// fatal when timer 2 expires in cascade mode

`timescale 1ns/1ns

module wdt_status_combiner
  import wdt_pkg::*;
(
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  wdt_timer_res_t t1_res_i,
  input  wdt_timer_res_t t2_res_i,
  input  wdt_service_t   service_i,
  input  logic           cascade_i,
  output wdt_status_t    status_o,
  output logic           irq_o,
  output logic           fatal_o
);

  logic        t1_prev_q;
  logic        t2_prev_q;
  logic        t1_rise;
  logic        t2_rise;
  wdt_status_t status_q;
  logic        fatal_q;

  //////////////////////////////////////////////////
  // Edge detect
  //////////////////////////////////////////////////

  assign t1_rise = t1_res_i.timeout && !t1_prev_q;
  assign t2_rise = t2_res_i.timeout && !t2_prev_q;

  //////////////////////////////////////////////////
  // Sticky status and fatal
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      t1_prev_q <= 1'b0;
      t2_prev_q <= 1'b0;
      status_q  <= '0;
      fatal_q   <= 1'b0;
    end else begin
      t1_prev_q <= t1_res_i.timeout;
      t2_prev_q <= t2_res_i.timeout;
      // New expiry beats a service in the same cycle
      status_q.t1_timeout <= t1_rise || (status_q.t1_timeout && !service_i.t1);
      status_q.t2_timeout <= t2_rise || (status_q.t2_timeout && !service_i.t2);
      // Fatal sticks until reset
      fatal_q <= fatal_q || (status_q.t2_timeout && cascade_i);
    end
  end

  assign status_o = status_q;
  assign irq_o    = status_q.t1_timeout || status_q.t2_timeout;
  assign fatal_o  = fatal_q;

endmodule

// File: logic/wdt_timer.sv
// Watchdog timer
// Counts up while enabled until the count reaches the period, then
// raises a sticky timeout and holds the count. A restart zeroes the
// count and clears the timeout on the next cycle

`timescale 1ns/1ns
`include "wdt_macros.svh"

module wdt_timer
  import wdt_pkg::*;
(
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  wdt_timer_ctl_t ctl_i,
  output wdt_timer_res_t res_o
);

  logic [`WDT_CNT_W-1:0] count_q;
  logic                  timeout_q;
  logic                  hit;
  logic                  timeout;

  //////////////////////////////////////////////////
  // Period compare
  //////////////////////////////////////////////////

  // Timeout shows in the same cycle the count lands on the period
  // A period lowered below a running count also trips at once
  assign hit     = ctl_i.en && (count_q >= ctl_i.period);
  assign timeout = timeout_q || hit;

  //////////////////////////////////////////////////
  // Counter
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q <= '0;
    end else if (ctl_i.restart) begin
      // Restart wins over counting
      count_q <= '0;
    end else if (ctl_i.en && !timeout) begin
      count_q <= count_q + 1'b1;
    end
    // Disabled or expired, count holds
  end

  // Sticky flag keeps the timeout once enable drops
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      timeout_q <= 1'b0;
    end else if (ctl_i.restart) begin
      timeout_q <= 1'b0;
    end else begin
      timeout_q <= timeout;
    end
  end

  assign res_o.timeout = timeout;
  assign res_o.count   = count_q;

endmodule

// File: logic/wdt_top.sv
// Two-stage watchdog subsystem
// APB register file driving two timers whose results merge into
// sticky status, one interrupt and a cascade fatal output

`timescale 1ns/1ns

module wdt_top
  import wdt_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  apb_req_t apb_req_i,
  output apb_rsp_t apb_rsp_o,
  output logic     irq_o,
  output logic     fatal_o
);

  wdt_timer_ctl_t t1_ctl;
  wdt_timer_ctl_t t2_ctl;
  wdt_timer_res_t t1_res;
  wdt_timer_res_t t2_res;
  wdt_service_t   service;
  wdt_status_t    status;
  logic           cascade;

  // Software side
  wdt_apb_regs u_regs (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .apb_req_i (apb_req_i),
    .apb_rsp_o (apb_rsp_o),
    .status_i  (status),
    .t1_ctl_o  (t1_ctl),
    .t2_ctl_o  (t2_ctl),
    .service_o (service),
    .cascade_o (cascade)
  );

  // First stage
  wdt_timer u_timer1 (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .ctl_i    (t1_ctl),
    .res_o    (t1_res)
  );

  // Second stage, gated by timer 1 status in cascade mode
  wdt_timer u_timer2 (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .ctl_i    (t2_ctl),
    .res_o    (t2_res)
  );

  wdt_status_combiner u_combiner (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .t1_res_i  (t1_res),
    .t2_res_i  (t2_res),
    .service_i (service),
    .cascade_i (cascade),
    .status_o  (status),
    .irq_o     (irq_o),
    .fatal_o   (fatal_o)
  );

endmodule

// File: test/wdt_top_assertions.sv
// Watchdog protocol assertions
// Bound into the top level to check timer restart, status timing and
// the cascade gating of the fatal output

`timescale 1ns/1ns

module wdt_top_assertions
  import wdt_pkg::*;
(
  input logic           clk_i,
  input logic           arst_n_i,
  input wdt_timer_ctl_t t1_ctl_i,
  input wdt_timer_ctl_t t2_ctl_i,
  input wdt_timer_res_t t1_res_i,
  input wdt_timer_res_t t2_res_i,
  input wdt_status_t    status_i,
  input logic           cascade_i,
  input logic           fatal_i
);

  // Running count of failed assertions
  int fail_count = 0;

  //////////////////////////////////////////////////
  // Restart zeroes the count one cycle later
  //////////////////////////////////////////////////

  t1_restart_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    t1_ctl_i.restart |=> (t1_res_i.count == '0))
    else begin
      fail_count++;
      $error("timer 1 count not zero after restart");
    end

  t2_restart_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    t2_ctl_i.restart |=> (t2_res_i.count == '0))
    else begin
      fail_count++;
      $error("timer 2 count not zero after restart");
    end

  //////////////////////////////////////////////////
  // Status follows a rising timeout by one cycle
  //////////////////////////////////////////////////

  t1_status_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(t1_res_i.timeout) |=> status_i.t1_timeout)
    else begin
      fail_count++;
      $error("status bit 0 missing after timer 1 timeout");
    end

  t2_status_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(t2_res_i.timeout) |=> status_i.t2_timeout)
    else begin
      fail_count++;
      $error("status bit 1 missing after timer 2 timeout");
    end

  // Fatal is registered, so cascade is looked at one cycle back
  fatal_gate_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(fatal_i) |-> $past(cascade_i))
    else begin
      fail_count++;
      $error("fatal rose outside cascade mode");
    end

endmodule

// File: test/wdt_top_tb.sv
// Watchdog subsystem testbench
// Drives the APB port through register access, independent timeouts,
// petting, cascade and service, and checks irq and fatal every cycle

`timescale 1ns/1ns
`include "wdt_macros.svh"

module wdt_top_tb
  import wdt_pkg::*;
();

  // Five tests of at most about 400 cycles plus margin
  localparam int TEST_CYCLES = 400;
  localparam int CYCLE_LIMIT = 5 * TEST_CYCLES + 1000;

  logic        clk_i;
  logic        arst_n_i;
  apb_req_t    apb_req_i;
  apb_rsp_t    apb_rsp_o;
  logic        irq_o;
  logic        fatal_o;
  int          seed;
  int          cycle = 0;
  int          read_cycle;
  int          errors;
  int          test_errors;
  int          tests_failed;
  // Model state with the start edges of enable or the last pet
  bit          armed;
  bit          casc;
  int          per1;
  int          per2;
  int          start1;
  int          start2;
  apb_rsp_t    rsp;
  wdt_status_t st;

  wdt_top u_wdt_top (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .apb_req_i (apb_req_i),
    .apb_rsp_o (apb_rsp_o),
    .irq_o     (irq_o),
    .fatal_o   (fatal_o)
  );

  bind wdt_top wdt_top_assertions u_assertions (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .t1_ctl_i  (t1_ctl),
    .t2_ctl_i  (t2_ctl),
    .t1_res_i  (t1_res),
    .t2_res_i  (t2_res),
    .status_i  (status),
    .cascade_i (cascade),
    .fatal_i   (fatal_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Cycle count for the model and the run limit
  always @(posedge clk_i) begin
    cycle = cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      $display("Timeout, run stopped after %0d cycles", cycle);
      $display("Finished with errors");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Reference model and compare tasks
  //////////////////////////////////////////////////

  // Status n1 and n2 edges after each timer was started or petted
  function automatic wdt_status_t expected_status(bit cascade, int p1, int p2, int n1, int n2);
    wdt_status_t s;
    s.t1_timeout = (n1 >= p1 + 1);
    // In cascade mode timer 2 starts one edge after the t1 status bit sets
    if (cascade) begin
      s.t2_timeout = (n1 >= p1 + p2 + 2);
    end else begin
      s.t2_timeout = (n2 >= p2 + 1);
    end
    return s;
  endfunction

  function automatic int rand_period();
    return 4 + ($unsigned($random(seed)) % 37);
  endfunction

  // Testbench errors plus failed bound assertions
  function automatic int total_errors();
    return errors + u_wdt_top.u_assertions.fail_count;
  endfunction

  task automatic check_status(string what, wdt_status_t got, wdt_status_t exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_rsp(string what, apb_rsp_t got, apb_rsp_t exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(string what, logic got, logic exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // Per-cycle check of irq_o and fatal_o against the model
  always @(negedge clk_i) begin : compare
    wdt_status_t now_s;
    wdt_status_t prev_s;
    if (armed) begin
      now_s  = expected_status(casc, per1, per2, cycle - start1, cycle - start2);
      prev_s = expected_status(casc, per1, per2, cycle - start1 - 1, cycle - start2 - 1);
      check_bit("irq_o", irq_o, now_s.t1_timeout || now_s.t2_timeout);
      check_bit("fatal_o", fatal_o, casc && prev_s.t2_timeout);
    end
  end

  //////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////

  task automatic step(int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  // Setup cycle then access cycle with the response taken mid access
  task automatic apb_xfer(bit wr, logic [`WDT_ADDR_W-1:0] addr, logic [31:0] data,
                          output apb_rsp_t r);
    apb_req_i = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: data};
    step(1);
    apb_req_i.penable = 1'b1;
    @(negedge clk_i);
    r          = apb_rsp_o;
    read_cycle = cycle;
    step(1);
    apb_req_i = '0;
  endtask

  task automatic apb_write(logic [`WDT_ADDR_W-1:0] addr, logic [31:0] data,
                           output apb_rsp_t r);
    apb_xfer(1'b1, addr, data, r);
  endtask

  task automatic apb_read(logic [`WDT_ADDR_W-1:0] addr, output apb_rsp_t r);
    apb_xfer(1'b0, addr, '0, r);
  endtask

  task automatic expect_read(string what, logic [`WDT_ADDR_W-1:0] addr, logic [31:0] data);
    apb_rsp_t r;
    apb_read(addr, r);
    check_rsp(what, r, '{prdata: data, pready: 1'b1, pslverr: 1'b0});
  endtask

  // STATUS read checked against the model at the sampling cycle
  task automatic read_status(output wdt_status_t s);
    apb_rsp_t r;
    apb_read(`WDT_STATUS_OFF, r);
    s = wdt_status_t'(r.prdata[1:0]);
    check_status("STATUS", s, expected_status(casc, per1, per2,
                 read_cycle - start1, read_cycle - start2));
  endtask

  // Configure periods and mode and start the model
  task automatic start_wdt(int p1, int p2, bit cascade);
    apb_rsp_t r;
    per1 = p1;
    per2 = p2;
    casc = cascade;
    apb_write(`WDT_T1_PERIOD_OFF, p1, r);
    apb_write(`WDT_T2_PERIOD_OFF, p2, r);
    apb_write(`WDT_CTRL_OFF, {30'd0, !cascade, 1'b1}, r);
    start1 = cycle;
    start2 = cycle;
    armed  = 1'b1;
  endtask

  task automatic apply_reset();
    armed     = 1'b0;
    apb_req_i = '0;
    arst_n_i  = 1'b0;
    step(2);
    arst_n_i  = 1'b1;
    test_errors = total_errors();
  endtask

  task automatic end_test(string name);
    armed = 1'b0;
    if (total_errors() == test_errors) begin
      $display("%-20s passed", name);
    end else begin
      tests_failed++;
      $display("%-20s failed with %0d errors", name, total_errors() - test_errors);
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  initial begin
    seed         = 96;
    errors       = 0;
    tests_failed = 0;
    armed        = 1'b0;
    arst_n_i     = 1'b0;
    apb_req_i    = '0;

    // Register access with the watchdog left disabled
    apply_reset();
    apb_write(`WDT_T1_PERIOD_OFF, 32'h0000_1234, rsp);
    apb_write(`WDT_T2_PERIOD_OFF, 32'h0000_00ab, rsp);
    apb_write(`WDT_CTRL_OFF, 32'h2, rsp);
    apb_write(`WDT_PET_OFF, 32'h3, rsp);
    expect_read("T1_PERIOD", `WDT_T1_PERIOD_OFF, 32'h0000_1234);
    expect_read("T2_PERIOD", `WDT_T2_PERIOD_OFF, 32'h0000_00ab);
    expect_read("CTRL", `WDT_CTRL_OFF, 32'h2);
    expect_read("PET", `WDT_PET_OFF, 32'h0);
    apb_write(8'h20, 32'hffff_ffff, rsp);
    check_bit("pslverr", rsp.pslverr, 1'b1);
    apb_read(8'h20, rsp);
    check_rsp("unmapped read", rsp, '{prdata: '0, pready: 1'b1, pslverr: 1'b1});
    expect_read("CTRL", `WDT_CTRL_OFF, 32'h2);
    expect_read("T1_PERIOD", `WDT_T1_PERIOD_OFF, 32'h0000_1234);
    end_test("register access");

    // Independent mode polls STATUS until both bits are up
    apply_reset();
    start_wdt(rand_period(), rand_period(), 1'b0);
    st = '0;
    while (!(st.t1_timeout && st.t2_timeout)) begin
      read_status(st);
    end
    end_test("independent");

    // Pet timer 1 four times two cycles short of its period
    apply_reset();
    start_wdt(rand_period(), rand_period(), 1'b1);
    repeat (4) begin
      step(per1 - 4);
      apb_write(`WDT_PET_OFF, 32'h1, rsp);
      start1 = cycle;
    end
    read_status(st);
    while (!irq_o) step(1);
    read_status(st);
    end_test("petting");

    // Cascade with timer 1 left unserviced until fatal
    apply_reset();
    start_wdt(rand_period(), rand_period(), 1'b1);
    while (!irq_o) step(1);
    read_status(st);
    while (!fatal_o) step(1);
    read_status(st);
    step(20);
    check_bit("fatal_o", fatal_o, 1'b1);
    end_test("cascade");

    // Service of timer 1 with timer 2 kept far off
    apply_reset();
    start_wdt(rand_period(), 1000, 1'b0);
    while (!irq_o) step(1);
    step(3);
    apb_write(`WDT_STATUS_OFF, 32'h1, rsp);
    start1 = cycle;
    check_bit("irq_o", irq_o, 1'b0);
    read_status(st);
    while (!irq_o) step(1);
    read_status(st);
    end_test("service");

    $display("5 tests run, %0d failed, %0d errors", tests_failed, total_errors());
    if (total_errors() == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: wdt_sub.f
+incdir+logic
logic/wdt_pkg.sv
logic/wdt_apb_regs.sv
logic/wdt_timer.sv
logic/wdt_status_combiner.sv
logic/wdt_top.sv
test/wdt_top_assertions.sv
test/wdt_top_tb.sv
